//--- logic/mipsPkg.sv
`default_nettype none

package mipsPkg;

	//////////////////////////////
	// Opcode field
	//////////////////////////////
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opJ       = 6'h02;
	localparam logic [5:0] opJal     = 6'h03;
	localparam logic [5:0] opBeq     = 6'h04;
	localparam logic [5:0] opAddiu   = 6'h09;
	localparam logic [5:0] opOri     = 6'h0d;
	localparam logic [5:0] opLui     = 6'h0f;
	localparam logic [5:0] opCop0    = 6'h10;
	localparam logic [5:0] opLw      = 6'h23;
	localparam logic [5:0] opSw      = 6'h2b;

	// Funct field of SPECIAL and COP0 words
	localparam logic [5:0] fnJr   = 6'h08;
	localparam logic [5:0] fnMfhi = 6'h10;
	localparam logic [5:0] fnMflo = 6'h12;
	localparam logic [5:0] fnMult = 6'h18;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;
	localparam logic [5:0] fnEret = 6'h18;

	// rs field of COP0 words
	localparam logic [4:0] cop0Mf = 5'h00;
	localparam logic [4:0] cop0Co = 5'h10;

	localparam logic [4:0] epcIndex = 5'd14;

	// Two device windows of three words each
	localparam logic [31:0] devBase0 = 32'h0000_7f00;
	localparam logic [31:0] devBase1 = 32'h0000_7f10;
	localparam int unsigned devWords = 3;

	//////////////////////////////
	// Select encodings
	//////////////////////////////
	typedef enum logic [2:0] {pcSeq, pcBranch, pcJump, pcReg, pcEpc} pcSelE;
	typedef enum logic [1:0] {dstRd, dstRt, dst31, dstNone} regDstE;
	typedef enum logic [2:0] {dataAlu, dataLoad, dataLink, dataHi, dataLo, dataCp0} regDataE;
	typedef enum logic {bReg, bImm} aluBE;
	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpE;

	typedef struct packed {
		pcSelE      pcSel;
		regDstE     regDst;
		regDataE    regData;
		aluBE       aluB;
		aluOpE      aluOp;
		logic       isBranch;
		logic       memRead;
		logic       memStore;
		logic       isMult;
		logic       isEret;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] cp0Reg;
	} ctrlT;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        memWrite;
		logic        devWrite;
	} busReqT;

	typedef struct packed {
		logic        en;
		logic [4:0]  addr;
		logic [31:0] data;
	} regWriteT;

endpackage

`default_nettype wire

//--- logic/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode import mipsPkg::*; (
	input  wire logic [31:0] instr,
	output ctrlT             ctrl,
	output logic [31:0]      imm
);

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	// Immediate extension per opcode
	always_comb begin
		case (opcode)
			opOri:   imm = {16'h0000, instr[15:0]};
			opLui:   imm = {instr[15:0], 16'h0000};
			default: imm = {{16{instr[15]}}, instr[15:0]};
		endcase
	end

	always_comb begin
		// Anything unrecognised falls through as a nop
		ctrl = '0;
		ctrl.pcSel   = pcSeq;
		ctrl.regDst  = dstNone;
		ctrl.regData = dataAlu;
		ctrl.aluB    = bReg;
		ctrl.aluOp   = aluAdd;
		ctrl.rs      = instr[25:21];
		ctrl.rt      = instr[20:16];
		ctrl.rd      = instr[15:11];

		case (opcode)
			opSpecial: begin
				case (funct)
					fnAddu: ctrl.regDst = dstRd;
					fnSubu: begin
						ctrl.regDst = dstRd;
						ctrl.aluOp  = aluSub;
					end
					fnAnd: begin
						ctrl.regDst = dstRd;
						ctrl.aluOp  = aluAnd;
					end
					fnOr: begin
						ctrl.regDst = dstRd;
						ctrl.aluOp  = aluOr;
					end
					fnSlt: begin
						ctrl.regDst = dstRd;
						ctrl.aluOp  = aluSlt;
					end
					fnJr:   ctrl.pcSel  = pcReg;
					fnMult: ctrl.isMult = 1'b1;
					fnMfhi: begin
						ctrl.regDst  = dstRd;
						ctrl.regData = dataHi;
					end
					fnMflo: begin
						ctrl.regDst  = dstRd;
						ctrl.regData = dataLo;
					end
					default: ;
				endcase
			end
			opAddiu: begin
				ctrl.regDst = dstRt;
				ctrl.aluB   = bImm;
			end
			opOri: begin
				ctrl.regDst = dstRt;
				ctrl.aluB   = bImm;
				ctrl.aluOp  = aluOr;
			end
			opLui: begin
				ctrl.regDst = dstRt;
				ctrl.aluB   = bImm;
				ctrl.aluOp  = aluLui;
			end
			opLw: begin
				ctrl.regDst  = dstRt;
				ctrl.regData = dataLoad;
				ctrl.aluB    = bImm;
				ctrl.memRead = 1'b1;
			end
			opSw: begin
				ctrl.aluB     = bImm;
				ctrl.memStore = 1'b1;
			end
			opBeq: begin
				ctrl.pcSel    = pcBranch;
				ctrl.isBranch = 1'b1;
			end
			opJ: ctrl.pcSel = pcJump;
			opJal: begin
				ctrl.pcSel   = pcJump;
				ctrl.regDst  = dst31;
				ctrl.regData = dataLink;
			end
			opCop0: begin
				// mfc0 writes rt, eret is the CO form with its own funct
				if (ctrl.rs == cop0Mf) begin
					ctrl.regDst  = dstRt;
					ctrl.regData = dataCp0;
					ctrl.cp0Reg  = instr[15:11];
				end else if (ctrl.rs == cop0Co && funct == fnEret) begin
					ctrl.pcSel  = pcEpc;
					ctrl.isEret = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import mipsPkg::*; (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic [4:0]  rsAddr,
	input  wire logic [4:0]  rtAddr,
	input  wire regWriteT    wr,
	output logic [31:0]      rsData,
	output logic [31:0]      rtData
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en && wr.addr != 5'd0) begin
			regs[wr.addr] <= wr.data;
		end
	end

	// Old contents visible until the edge
	assign rsData = (rsAddr == 5'd0) ? 32'h0 : regs[rsAddr];
	assign rtData = (rtAddr == 5'd0) ? 32'h0 : regs[rtAddr];

endmodule

`default_nettype wire

//--- logic/aluExecute.sv
`timescale 1ns/1ps
`default_nettype none

module aluExecute import mipsPkg::*; (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire ctrlT        ctrl,
	input  wire logic        excTaken,
	input  wire logic [31:0] a,
	input  wire logic [31:0] b,
	output logic [31:0]      result,
	output logic             isEqual,
	output logic [31:0]      hi,
	output logic [31:0]      lo
);

	logic signed [63:0] product;

	//////////////////////////////
	// Combinational ALU
	//////////////////////////////
	always_comb begin
		case (ctrl.aluOp)
			aluAdd: result = a + b;
			aluSub: result = a - b;
			aluAnd: result = a & b;
			aluOr:  result = a | b;
			aluSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			// Decode already shifted the immediate into the upper half
			aluLui: result = b;
			default: result = a + b;
		endcase
	end

	// beq compares rs against rt through the B path
	assign isEqual = (a == b);

	//////////////////////////////
	// HI/LO product registers
	//////////////////////////////
	assign product = $signed(a) * $signed(b);

	always_ff @(posedge clk) begin
		if (reset) begin
			hi <= '0;
			lo <= '0;
		end else if (ctrl.isMult && !excTaken) begin
			hi <= product[63:32];
			lo <= product[31:0];
		end
	end

endmodule

`default_nettype wire

//--- logic/resultSelect.sv
`timescale 1ns/1ps
`default_nettype none

module resultSelect import mipsPkg::*; (
	input  wire ctrlT        ctrl,
	input  wire logic        excTaken,
	input  wire logic [31:0] rtData,
	input  wire logic [31:0] imm,
	input  wire logic [31:0] aluResult,
	input  wire logic [31:0] memRdata,
	input  wire logic [31:0] devRdata,
	input  wire logic [31:0] pc,
	input  wire logic [31:0] hi,
	input  wire logic [31:0] lo,
	input  wire logic [31:0] epc,
	output logic [31:0]      aluB,
	output busReqT           bus,
	output regWriteT         regWr
);

	logic        inDevWindow;
	logic [31:0] loadData;
	logic [31:0] cp0Data;

	assign aluB = (ctrl.aluB == bImm) ? imm : rtData;

	// Device windows, each three words long
	assign inDevWindow =
		(aluResult >= devBase0 && aluResult < devBase0 + 4 * devWords) ||
		(aluResult >= devBase1 && aluResult < devBase1 + 4 * devWords);

	assign loadData = (ctrl.memRead && inDevWindow) ? devRdata : memRdata;
	assign cp0Data  = (ctrl.cp0Reg == epcIndex) ? epc : 32'h0;

	//////////////////////////////
	// Register write-back
	//////////////////////////////
	always_comb begin
		regWr.en = (ctrl.regDst != dstNone) && !excTaken;

		case (ctrl.regDst)
			dstRd:   regWr.addr = ctrl.rd;
			dstRt:   regWr.addr = ctrl.rt;
			dst31:   regWr.addr = 5'd31;
			default: regWr.addr = 5'd0;
		endcase

		case (ctrl.regData)
			dataAlu:  regWr.data = aluResult;
			dataLoad: regWr.data = loadData;
			dataLink: regWr.data = pc + 32'd4;
			dataHi:   regWr.data = hi;
			dataLo:   regWr.data = lo;
			dataCp0:  regWr.data = cp0Data;
			default:  regWr.data = aluResult;
		endcase
	end

	// Store strobe split by address window
	always_comb begin
		bus.addr     = aluResult;
		bus.wdata    = rtData;
		bus.memWrite = ctrl.memStore && !inDevWindow && !excTaken;
		bus.devWrite = ctrl.memStore && inDevWindow && !excTaken;
	end

endmodule

`default_nettype wire

//--- logic/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit import mipsPkg::*; #(
	parameter logic [31:0] resetPc  = 32'h0000_3000,
	parameter logic [31:0] excEntry = 32'h0000_4180
) (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        intReq,
	input  wire ctrlT        ctrl,
	input  wire logic [31:0] rsData,
	input  wire logic [31:0] imm,
	input  wire logic [25:0] jumpField,
	input  wire logic        isEqual,
	output logic [31:0]      pc,
	output logic [31:0]      epc,
	output logic             excTaken
);

	logic [31:0] pcPlus4;
	logic [31:0] nextPc;

	// Current instruction is dropped on an interrupt and while held in reset
	assign excTaken = intReq || reset;

	assign pcPlus4 = pc + 32'd4;

	always_comb begin
		case (ctrl.pcSel)
			pcBranch: nextPc = (ctrl.isBranch && isEqual) ? pcPlus4 + (imm << 2) : pcPlus4;
			pcJump:   nextPc = {pc[31:28], jumpField, 2'b00};
			pcReg:    nextPc = rsData;
			pcEpc:    nextPc = ctrl.isEret ? epc : pcPlus4;
			default:  nextPc = pcPlus4;
		endcase
	end

	//////////////////////////////
	// PC and EPC
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			pc  <= resetPc;
			epc <= '0;
		end else if (intReq) begin
			// Interrupted instruction reruns after eret
			pc  <= excEntry;
			epc <= pc;
		end else begin
			pc <= nextPc;
		end
	end

endmodule

`default_nettype wire

//--- logic/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore import mipsPkg::*; #(
	parameter logic [31:0] resetPc  = 32'h0000_3000,
	parameter logic [31:0] excEntry = 32'h0000_4180
) (
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic [31:0] instr,
	input  wire logic [31:0] memRdata,
	input  wire logic [31:0] devRdata,
	input  wire logic        intReq,
	output logic [31:0]      pc,
	output busReqT           bus,
	output regWriteT         regWr
);

	ctrlT        ctrl;
	logic [31:0] imm;
	logic [31:0] rsData;
	logic [31:0] rtData;
	logic [31:0] aluB;
	logic [31:0] aluResult;
	logic        isEqual;
	logic [31:0] hi;
	logic [31:0] lo;
	logic [31:0] epc;
	logic        excTaken;

	instrDecode decode0 (
		.instr (instr),
		.ctrl  (ctrl),
		.imm   (imm)
	);

	regFile regs0 (
		.clk    (clk),
		.reset  (reset),
		.rsAddr (ctrl.rs),
		.rtAddr (ctrl.rt),
		.wr     (regWr),
		.rsData (rsData),
		.rtData (rtData)
	);

	aluExecute alu0 (
		.clk      (clk),
		.reset    (reset),
		.ctrl     (ctrl),
		.excTaken (excTaken),
		.a        (rsData),
		.b        (aluB),
		.result   (aluResult),
		.isEqual  (isEqual),
		.hi       (hi),
		.lo       (lo)
	);

	resultSelect select0 (
		.ctrl      (ctrl),
		.excTaken  (excTaken),
		.rtData    (rtData),
		.imm       (imm),
		.aluResult (aluResult),
		.memRdata  (memRdata),
		.devRdata  (devRdata),
		.pc        (pc),
		.hi        (hi),
		.lo        (lo),
		.epc       (epc),
		.aluB      (aluB),
		.bus       (bus),
		.regWr     (regWr)
	);

	pcUnit #(
		.resetPc  (resetPc),
		.excEntry (excEntry)
	) pc0 (
		.clk       (clk),
		.reset     (reset),
		.intReq    (intReq),
		.ctrl      (ctrl),
		.rsData    (rsData),
		.imm       (imm),
		.jumpField (instr[25:0]),
		.isEqual   (isEqual),
		.pc        (pc),
		.epc       (epc),
		.excTaken  (excTaken)
	);

endmodule

`default_nettype wire

//--- bench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
	parameter int periodNs    = 40,
	parameter int resetCycles = 5
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	// Released just after the last reset edge
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

//--- bench/mipsCore_props.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore_props import mipsPkg::*; #(
	parameter logic [31:0] excEntry = 32'h0000_4180
) (
	input wire logic        clk,
	input wire logic        reset,
	input wire logic        intReq,
	input wire logic [31:0] pc,
	input wire busReqT      bus,
	input wire regWriteT    regWr
);

	int unsigned violations = 0;

	// One write strobe per store
	strobeExclusive: assert property (@(posedge clk) !(bus.memWrite && bus.devWrite))
		else begin
			$error("memWrite and devWrite asserted together");
			violations++;
		end

	// Interrupt redirects the fetch on the next cycle
	intEntry: assert property (@(posedge clk) disable iff (reset) intReq |=> pc == excEntry)
		else begin
			$error("pc did not move to the exception entry after intReq");
			violations++;
		end

	resetQuiet: assert property (@(posedge clk) reset |-> !regWr.en)
		else begin
			$error("register write enabled during reset");
			violations++;
		end

endmodule

`default_nettype wire

//--- bench/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb import mipsPkg::*; ;

	localparam int resetCycles = 5;

	// Assembler codes, opcode then funct
	localparam logic [5:0] codeJ     = 6'h02;
	localparam logic [5:0] codeJal   = 6'h03;
	localparam logic [5:0] codeBeq   = 6'h04;
	localparam logic [5:0] codeAddiu = 6'h09;
	localparam logic [5:0] codeOri   = 6'h0d;
	localparam logic [5:0] codeLui   = 6'h0f;
	localparam logic [5:0] codeLw    = 6'h23;
	localparam logic [5:0] codeSw    = 6'h2b;
	localparam logic [5:0] codeJr    = 6'h08;
	localparam logic [5:0] codeMfhi  = 6'h10;
	localparam logic [5:0] codeMflo  = 6'h12;
	localparam logic [5:0] codeMult  = 6'h18;
	localparam logic [5:0] codeAddu  = 6'h21;
	localparam logic [5:0] codeSubu  = 6'h23;
	localparam logic [5:0] codeAnd   = 6'h24;
	localparam logic [5:0] codeOr    = 6'h25;
	localparam logic [5:0] codeSlt   = 6'h2a;
	localparam logic [31:0] eretWord = 32'h4200_0018;

	typedef enum {srcNone, srcMem, srcDev} loadSrcE;
	typedef enum {careStrobes, careAddr, careAll} busCareE;

	typedef struct {
		logic [31:0] pc;
		logic [31:0] instr;
		regWriteT    wr;
		busReqT      bus;
		busCareE     care;
		loadSrcE     src;
		logic        intReq;
	} rowT;

	localparam regWriteT noWr  = '0;
	localparam busReqT   noBus = '0;

	logic        clk;
	logic        reset;
	logic [31:0] instr;
	logic [31:0] memRdata;
	logic [31:0] devRdata;
	logic        intReq;
	logic [31:0] pc;
	busReqT      bus;
	regWriteT    regWr;

	rowT         rows[$];
	logic [31:0] lcgState = 32'd15443;
	int          curRow;
	int          rowErrors;
	int          cycles = 0;
	int          cycleLimit = 1000;

	clockGen #(.periodNs(40), .resetCycles(resetCycles)) clk0 (
		.clk   (clk),
		.reset (reset)
	);

	mipsCore dut0 (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.memRdata (memRdata),
		.devRdata (devRdata),
		.intReq   (intReq),
		.pc       (pc),
		.bus      (bus),
		.regWr    (regWr)
	);

	bind mipsCore mipsCore_props #(.excEntry(excEntry)) props0 (
		.clk    (clk),
		.reset  (reset),
		.intReq (intReq),
		.pc     (pc),
		.bus    (bus),
		.regWr  (regWr)
	);

	//////////////////////////////
	// Encoders and table helpers
	//////////////////////////////
	function automatic logic [31:0] encodeR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
			logic [5:0] funct);
		return {6'h00, rs, rt, rd, 5'h00, funct};
	endfunction

	function automatic logic [31:0] encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] encodeJ(logic [5:0] op, logic [31:0] target);
		return {op, target[27:2]};
	endfunction

	// mfc0 rt, rd
	function automatic logic [31:0] encodeMfc0(logic [4:0] rt, logic [4:0] rd);
		return {6'h10, 5'h00, rt, rd, 11'h000};
	endfunction

	function automatic regWriteT wrOf(logic [4:0] addr, logic [31:0] data);
		return '{en: 1'b1, addr: addr, data: data};
	endfunction

	function automatic busReqT storeOf(logic [31:0] addr, logic [31:0] data, logic dev);
		return '{addr: addr, wdata: data, memWrite: !dev, devWrite: dev};
	endfunction

	function automatic busReqT addrOf(logic [31:0] addr);
		return '{addr: addr, wdata: 32'h0, memWrite: 1'b0, devWrite: 1'b0};
	endfunction

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic addRow(logic [31:0] pcVal, logic [31:0] word, regWriteT wr,
			busReqT req = noBus, busCareE care = careStrobes, loadSrcE src = srcNone,
			logic irq = 1'b0);
		rows.push_back('{pcVal, word, wr, req, care, src, irq});
	endtask

	task automatic buildTable();
		// ALU work from the reset address
		addRow(32'h3000, encodeI(codeOri, 0, 1, 16'h1234), wrOf(1, 32'h0000_1234));
		addRow(32'h3004, encodeI(codeLui, 0, 2, 16'h8000), wrOf(2, 32'h8000_0000));
		addRow(32'h3008, encodeI(codeAddiu, 0, 3, 16'hfffb), wrOf(3, 32'hffff_fffb));
		addRow(32'h300c, encodeR(1, 2, 4, codeAddu), wrOf(4, 32'h8000_1234));
		addRow(32'h3010, encodeR(1, 3, 5, codeSubu), wrOf(5, 32'h0000_1239));
		addRow(32'h3014, encodeR(4, 3, 6, codeAnd), wrOf(6, 32'h8000_1230));
		addRow(32'h3018, encodeR(1, 2, 7, codeOr), wrOf(7, 32'h8000_1234));
		addRow(32'h301c, encodeR(2, 1, 8, codeSlt), wrOf(8, 32'h0000_0001));
		addRow(32'h3020, encodeR(1, 3, 9, codeSlt), wrOf(9, 32'h0000_0000));
		addRow(32'h3024, encodeR(1, 1, 0, codeAddu), wrOf(0, 32'h0000_2468));
		// r0 must still read as zero
		addRow(32'h3028, encodeR(0, 1, 10, codeAddu), wrOf(10, 32'h0000_1234));

		// Branches and jumps
		addRow(32'h302c, encodeI(codeBeq, 1, 7, 16'h0002), noWr);
		addRow(32'h3030, encodeI(codeBeq, 4, 7, 16'h0003), noWr);
		addRow(32'h3040, encodeJ(codeJ, 32'h3100), noWr);
		addRow(32'h3100, encodeJ(codeJal, 32'h3200), wrOf(31, 32'h0000_3104));
		addRow(32'h3200, encodeI(codeOri, 0, 11, 16'h3300), wrOf(11, 32'h0000_3300));
		addRow(32'h3204, encodeR(11, 0, 0, codeJr), noWr);

		// Loads and stores around the device windows
		addRow(32'h3300, encodeI(codeLw, 0, 12, 16'h0100), wrOf(12, 0),
			addrOf(32'h0100), careAddr, srcMem);
		addRow(32'h3304, encodeI(codeLw, 0, 13, 16'h7f00), wrOf(13, 0),
			addrOf(32'h7f00), careAddr, srcDev);
		addRow(32'h3308, encodeI(codeLw, 0, 14, 16'h7f18), wrOf(14, 0),
			addrOf(32'h7f18), careAddr, srcDev);
		addRow(32'h330c, encodeI(codeLw, 0, 15, 16'h7f0c), wrOf(15, 0),
			addrOf(32'h7f0c), careAddr, srcMem);
		addRow(32'h3310, encodeI(codeSw, 0, 1, 16'h0200), noWr,
			storeOf(32'h0200, 32'h0000_1234, 1'b0), careAll);
		addRow(32'h3314, encodeI(codeSw, 0, 4, 16'h7f04), noWr,
			storeOf(32'h7f04, 32'h8000_1234, 1'b1), careAll);
		addRow(32'h3318, encodeI(codeSw, 0, 6, 16'h7f14), noWr,
			storeOf(32'h7f14, 32'h8000_1230, 1'b1), careAll);
		addRow(32'h331c, encodeI(codeSw, 0, 3, 16'h7f1c), noWr,
			storeOf(32'h7f1c, 32'hffff_fffb, 1'b0), careAll);

		// Two negative operands give a positive 64-bit product
		addRow(32'h3320, encodeR(4, 3, 0, codeMult), noWr);
		addRow(32'h3324, encodeR(0, 0, 16, codeMfhi), wrOf(16, 32'h0000_0002));
		addRow(32'h3328, encodeR(0, 0, 17, codeMflo), wrOf(17, 32'h7fff_a4fc));

		// Interrupt during addu, then return and rerun it
		addRow(32'h332c, encodeR(1, 1, 18, codeAddu), noWr, noBus, careStrobes, srcNone, 1'b1);
		addRow(32'h4180, encodeMfc0(19, 14), wrOf(19, 32'h0000_332c));
		addRow(32'h4184, encodeMfc0(20, 12), wrOf(20, 32'h0000_0000));
		addRow(32'h4188, eretWord, noWr);
		addRow(32'h332c, encodeR(1, 1, 18, codeAddu), wrOf(18, 32'h0000_2468));
		addRow(32'h3330, encodeR(18, 0, 21, codeAddu), wrOf(21, 32'h0000_2468));
	endtask

	//////////////////////////////
	// Compare tasks
	//////////////////////////////
	task automatic reportMismatch(string name, logic [31:0] exp, logic [31:0] act);
		$display("MISMATCH row %0d %s expected %h got %h", curRow, name, exp, act);
		rowErrors++;
	endtask

	task automatic checkWord(string name, logic [31:0] exp, logic [31:0] act);
		if (act !== exp)
			reportMismatch(name, exp, act);
	endtask

	task automatic checkRegWrite(regWriteT exp, regWriteT act);
		if (act.en !== exp.en) begin
			reportMismatch("regWr.en", exp.en, act.en);
		end else if (exp.en) begin
			if (act.addr !== exp.addr)
				reportMismatch("regWr.addr", exp.addr, act.addr);
			if (act.data !== exp.data)
				reportMismatch("regWr.data", exp.data, act.data);
		end
	endtask

	task automatic checkBus(busReqT exp, busReqT act, busCareE care);
		if (act.memWrite !== exp.memWrite)
			reportMismatch("bus.memWrite", exp.memWrite, act.memWrite);
		if (act.devWrite !== exp.devWrite)
			reportMismatch("bus.devWrite", exp.devWrite, act.devWrite);
		if (care != careStrobes && act.addr !== exp.addr)
			reportMismatch("bus.addr", exp.addr, act.addr);
		if (care == careAll && act.wdata !== exp.wdata)
			reportMismatch("bus.wdata", exp.wdata, act.wdata);
	endtask

	// Watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("Timeout: simulation ran past %0d cycles", cycleLimit);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		regWriteT    expWr;
		logic [31:0] memWord;
		logic [31:0] devWord;
		int          passed;
		int          failed;

		passed = 0;
		failed = 0;
		// A register write held off by reset
		instr = encodeI(codeOri, 0, 1, 16'h5a5a);
		intReq = 1'b0;
		memRdata = 32'h0;
		devRdata = 32'h0;
		buildTable();
		cycleLimit = rows.size() + resetCycles + 20;

		// Row 0 goes in on the last reset edge
		repeat (resetCycles - 1) @(posedge clk);
		foreach (rows[i]) begin
			@(posedge clk);
			memWord = lcgNext();
			devWord = lcgNext();
			instr <= rows[i].instr;
			intReq <= rows[i].intReq;
			memRdata <= memWord;
			devRdata <= devWord;

			@(negedge clk);
			curRow = i;
			rowErrors = 0;
			expWr = rows[i].wr;
			if (rows[i].src == srcMem)
				expWr.data = memWord;
			else if (rows[i].src == srcDev)
				expWr.data = devWord;
			if (reset) begin
				$display("Row %0d applied while reset was still asserted", i);
				rowErrors++;
			end
			checkWord("pc", rows[i].pc, pc);
			checkRegWrite(expWr, regWr);
			checkBus(rows[i].bus, bus, rows[i].care);
			$display("row %0d pc %h %s", i, rows[i].pc, rowErrors == 0 ? "ok" : "failed");
			if (rowErrors == 0)
				passed++;
			else
				failed++;
		end

		@(posedge clk);
		instr <= 32'h0;
		intReq <= 1'b0;
		@(negedge clk);
		$display("%0d rows passed, %0d rows failed, %0d assertion failures",
			passed, failed, dut0.props0.violations);
		if (failed == 0 && dut0.props0.violations == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- mipsCore.f
logic/mipsPkg.sv
logic/instrDecode.sv
logic/regFile.sv
logic/aluExecute.sv
logic/resultSelect.sv
logic/pcUnit.sv
logic/mipsCore.sv
bench/clockGen.sv
bench/mipsCore_props.sv
bench/mipsCoreTb.sv
